// File: Bender.yml
package:
  name: ddr_bridge

export_include_dirs:
  - hw

sources:
  - hw/ddr_bridge_pkg.sv
  - hw/req_fifo.sv
  - hw/axil_req_decode.sv
  - hw/ddr_cmd_arbiter.sv
  - hw/rd_data_return.sv
  - hw/ddr_bridge_top.sv
  - target: simulation
    files:
      - dv/ddr_mem_model.sv
      - dv/tb_ddr_bridge.sv

// File: dv/ddr_mem_model.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module ddr_mem_model #(
  parameter logic [31:0] SEED   = 32'he95b_f38d,
  parameter int          RD_LAT = 6
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          app_en,
  input  ddr_bridge_pkg::app_cmd_e      app_cmd,
  input  logic [`DDR_ADDR_W-1:0]        app_addr,
  input  logic                          app_wdf_wren,
  input  logic                          app_wdf_end,
  input  logic [`DDR_DATA_W-1:0]        app_wdf_data,
  input  logic [`DDR_MASK_W-1:0]        app_wdf_mask,
  output logic                          app_rdy,
  output logic                          app_wdf_rdy,
  output logic                          app_rd_data_valid,
  output logic [`DDR_DATA_W-1:0]        app_rd_data,
  output logic                          proto_err
);

  logic [`DDR_DATA_W-1:0]             mem [`MEM_WORDS];
  logic [31:0]                        lfsr;
  logic [`DDR_ADDR_W-1:0]             cmd_q [$];    // Write addresses waiting for a beat
  logic [`DDR_MASK_W+`DDR_DATA_W-1:0] beat_q [$];
  logic                               rv_pipe [RD_LAT];
  logic [`DDR_DATA_W-1:0]             rd_pipe [RD_LAT];

  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return b;
  endfunction

  initial begin
    lfsr        = SEED;
    app_rdy     = 1'b0;
    app_wdf_rdy = 1'b0;
    proto_err   = 1'b0;
    for (int i = 0; i < RD_LAT; i++) begin
      rv_pipe[i] = 1'b0;
      rd_pipe[i] = '0;
    end
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;   // Hashed from the full address
    end
  end

  always @(posedge clk) begin
    logic                               rd_take;
    logic [`DDR_ADDR_W-1:0]             a;
    logic [`DDR_MASK_W+`DDR_DATA_W-1:0] beat;
    rd_take = app_en & app_rdy & (app_cmd == ddr_bridge_pkg::CMD_READ);
    if (!rst_n) begin
      app_rdy     <= 1'b0;
      app_wdf_rdy <= 1'b0;
      proto_err   <= 1'b0;
      for (int i = 0; i < RD_LAT; i++) begin
        rv_pipe[i] <= 1'b0;
      end
    end else begin
      // Roughly one stall cycle in four on each ready
      app_rdy     <= next_bit() | next_bit();
      app_wdf_rdy <= next_bit() | next_bit();
      if (app_en && app_rdy && app_addr >= `MEM_WORDS) begin
        proto_err <= 1'b1;
      end
      if (app_wdf_wren && !app_wdf_end) begin
        proto_err <= 1'b1;
      end
      rv_pipe[0] <= rd_take;
      rd_pipe[0] <= (app_addr < `MEM_WORDS) ? mem[app_addr] : '0;
      for (int i = 1; i < RD_LAT; i++) begin
        rv_pipe[i] <= rv_pipe[i-1];
        rd_pipe[i] <= rd_pipe[i-1];
      end
      if (app_en && app_rdy && app_cmd == ddr_bridge_pkg::CMD_WRITE) begin
        cmd_q.push_back(app_addr);
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        beat_q.push_back({app_wdf_mask, app_wdf_data});
      end
      // Commit once a command has met its beat
      while (cmd_q.size() > 0 && beat_q.size() > 0) begin
        a    = cmd_q.pop_front();
        beat = beat_q.pop_front();
        for (int b = 0; b < `DDR_MASK_W; b++) begin
          if (!beat[`DDR_DATA_W+b] && a < `MEM_WORDS) begin
            mem[a][8*b +: 8] = beat[8*b +: 8];   // Mask bit 1 keeps the byte
          end
        end
      end
    end
  end

  assign app_rd_data_valid = rv_pipe[RD_LAT-1];
  assign app_rd_data       = rd_pipe[RD_LAT-1];

endmodule

// File: dv/tb_ddr_bridge.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module tb_ddr_bridge;

  localparam int         TIMEOUT_CYCLES = 8 * 64 * 40;
  localparam int         SETTLE_CYCLES  = 64;
  localparam logic [1:0] OKAY           = 2'b00;
  localparam logic [1:0] SLVERR         = 2'b10;

  logic                     clk;
  logic                     rst_n;
  logic [`AXI_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`DDR_DATA_W-1:0]   wdata;
  logic [`DDR_MASK_W-1:0]   wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [`AXI_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [`DDR_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;
  logic                     app_rdy;
  logic                     app_wdf_rdy;
  logic                     app_rd_data_valid;
  logic [`DDR_DATA_W-1:0]   app_rd_data;
  logic                     app_en;
  ddr_bridge_pkg::app_cmd_e app_cmd;
  logic [`DDR_ADDR_W-1:0]   app_addr;
  logic                     app_wdf_wren;
  logic                     app_wdf_end;
  logic [`DDR_DATA_W-1:0]   app_wdf_data;
  logic [`DDR_MASK_W-1:0]   app_wdf_mask;
  logic                     proto_err;

  logic [`DDR_DATA_W-1:0]   shadow [`MEM_WORDS];
  logic [31:0]              lfsr;
  logic [`DDR_DATA_W-1:0]   exp_data_q [$];   // Expected R beats in issue order
  logic [1:0]               exp_resp_q [$];
  int                       err_cnt      = 0;
  int                       check_cnt    = 0;
  int                       test_cnt     = 0;
  int                       test_err0    = 0;
  int                       cycle_cnt    = 0;
  int                       idle_cnt     = 0;
  int                       to_write_cnt = 0;
  int                       to_read_cnt  = 0;
  logic                     last_valid;
  ddr_bridge_pkg::app_cmd_e last_cmd;

  ddr_bridge_top dut (.*);
  ddr_mem_model  u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // Reference model and helpers
  // ------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Byte address inside the memory
  function automatic logic in_range(input logic [31:0] addr);
    return addr < `MEM_WORDS * 4;
  endfunction

  // Strobed bytes replace the old word
  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [1:0] exp_resp;
    exp_resp = in_range(addr) ? OKAY : SLVERR;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    check_value("wready", 32'(wready), 32'd1);   // W goes with AW
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (exp_resp == OKAY) begin
      shadow[addr[31:2]] = merge_word(shadow[addr[31:2]], data, strb);
    end
    do @(posedge clk); while (!bvalid);
    check_value("bresp", 32'(bresp), 32'(exp_resp));
  endtask

  task automatic read_word(input logic [31:0] addr);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    exp_data_q.push_back(in_range(addr) ? shadow[addr[31:2]] : '0);
    exp_resp_q.push_back(in_range(addr) ? OKAY : SLVERR);
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
  endtask

  // B comes at queueing, so wait for the command bus to go quiet
  task automatic wait_settled();
    repeat (2) @(posedge clk);
    while (idle_cnt < SETTLE_CYCLES) @(posedge clk);
  endtask

  task automatic drain_reads();
    while (exp_resp_q.size() != 0) @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic random_words();
    int unsigned w [64];
    for (int i = 0; i < 64; i++) begin
      w[i] = rand_bits(12);
      write_word(w[i] << 2, rand_bits(32), 4'hf);
    end
    wait_settled();
    for (int i = 0; i < 64; i++) read_word(w[i] << 2);
    drain_reads();
    finish_test("random words");
  endtask

  task automatic partial_strobes();
    int unsigned w [8];
    int unsigned k;
    for (int i = 0; i < 8; i++) w[i] = rand_bits(12);
    for (int i = 0; i < 64; i++) begin
      k = rand_bits(3);   // Few words, so bytes merge many times
      write_word(w[k] << 2, rand_bits(32), 4'(rand_bits(4)));
    end
    wait_settled();
    for (int i = 0; i < 8; i++) read_word(w[i] << 2);
    drain_reads();
    finish_test("partial strobes");
  endtask

  task automatic out_of_range_access();
    int unsigned w;
    w = rand_bits(12);
    write_word(32'h0400_0000 | (w << 2), rand_bits(32), 4'hf);   // Aliases word w in DDR bits
    write_word(`MEM_WORDS * 4, rand_bits(32), 4'hf);             // First word past the end
    write_word(32'hffff_fffc, rand_bits(32), 4'hf);
    wait_settled();
    read_word(w << 2);
    read_word(`MEM_WORDS * 4 + (rand_bits(8) << 2));
    read_word(rand_bits(12) << 2);
    read_word(32'h8000_0000);
    read_word(rand_bits(12) << 2);
    drain_reads();
    finish_test("out of range");
  endtask

  task automatic rready_backpressure();
    @(posedge clk);
    rready <= 1'b0;
    fork
      begin
        for (int i = 0; i < 40; i++) read_word(rand_bits(12) << 2);
      end
      begin
        repeat (300) @(posedge clk);
        if (!arvalid || arready) begin
          err_cnt++;
          $display("AR was not held back while rready was low");
        end
        rready <= 1'b1;
      end
    join
    drain_reads();
    finish_test("backpressure");
  endtask

  task automatic mode_switching();
    int unsigned wr_list [$];
    int          to_wr0;
    int          to_rd0;
    to_wr0 = to_write_cnt;
    to_rd0 = to_read_cnt;
    for (int r = 0; r < 4; r++) begin
      fork
        begin
          int unsigned w;
          for (int i = 0; i < 16; i++) begin
            w = rand_bits(11);   // Lower half only
            wr_list.push_back(w);
            write_word(w << 2, rand_bits(32), 4'hf);
          end
        end
        begin
          for (int i = 0; i < 16; i++) read_word((rand_bits(11) | 32'h800) << 2);
        end
      join
    end
    drain_reads();
    wait_settled();
    if (to_write_cnt == to_wr0 || to_read_cnt == to_rd0) begin
      err_cnt++;
      $display("Arbiter did not switch between read and write in both directions");
    end
    foreach (wr_list[i]) read_word(wr_list[i] << 2);
    drain_reads();
    finish_test("mode switch");
  endtask

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(posedge clk) begin
    logic [`DDR_DATA_W-1:0] exp_data;
    logic [1:0]             exp_resp;
    if (rst_n && rvalid && rready) begin
      if (exp_resp_q.size() == 0) begin
        err_cnt++;
        $display("R response arrived with no read outstanding");
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_resp = exp_resp_q.pop_front();
        check_value("rresp", 32'(rresp), 32'(exp_resp));
        if (exp_resp == OKAY) begin
          check_value("rdata", rdata, exp_data);
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      idle_cnt   <= 0;
      last_valid <= 1'b0;
    end else begin
      idle_cnt <= app_en ? 0 : idle_cnt + 1;
      if (app_en && app_rdy) begin
        if (last_valid && app_cmd != last_cmd) begin
          if (app_cmd == ddr_bridge_pkg::CMD_WRITE) begin
            to_write_cnt <= to_write_cnt + 1;
          end else begin
            to_read_cnt <= to_read_cnt + 1;
          end
        end
        last_cmd   <= app_cmd;
        last_valid <= 1'b1;
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    lfsr    = 32'he95b_f38d;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      shadow[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;   // Same fill as the DDR model
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    random_words();
    partial_strobes();
    out_of_range_access();
    rready_backpressure();
    mode_switching();

    if (proto_err) begin
      err_cnt++;
      $display("DDR model saw an out-of-range address or a beat without app_wdf_end");
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: hw/axil_req_decode.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module axil_req_decode (
  input  logic                          clk,
  input  logic                          rst_n,
  // AXI4-Lite slave
  input  logic [`AXI_ADDR_W-1:0]        awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`DDR_DATA_W-1:0]        wdata,
  input  logic [`DDR_MASK_W-1:0]        wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [`AXI_ADDR_W-1:0]        araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`DDR_DATA_W-1:0]        rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // Request queues
  output logic                          wr_push,
  output ddr_bridge_pkg::wr_req_t       wr_req,
  input  logic                          wr_full,
  output logic                          rd_push,
  output ddr_bridge_pkg::rd_req_t       rd_req,
  input  logic                          rd_full,
  // Return path
  output logic                          err_push,
  input  ddr_bridge_pkg::rd_rsp_t       ret_head,
  input  logic                          ret_empty,
  output logic                          ret_pop,
  input  logic                          ret_room
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                wr_ok;
  logic                ar_ok;
  logic [`LEVEL_W:0]   rd_out;   // Good reads not yet delivered on R

  // ------------------------------
  // Write path
  // ------------------------------
  assign wr_ok   = (awaddr[`AXI_ADDR_W-1:2] < `MEM_WORDS);
  assign awready = awvalid & wvalid & ~bvalid & ~wr_full;   // AW and W together
  assign wready  = awready;
  assign wr_push = awready & wr_ok;

  assign wr_req.addr = awaddr[`DDR_ADDR_W+1:2];
  assign wr_req.data = wdata;
  assign wr_req.mask = ~wstrb;   // Controller masks on 1

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (awready) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (awready) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  // A rejected read waits until every earlier read is out on R,
  // so its marker lands in order
  assign ar_ok   = (araddr[`AXI_ADDR_W-1:2] < `MEM_WORDS);
  assign arready = arvalid & (ar_ok ? ~rd_full : (ret_room & (rd_out == '0)));
  assign rd_push  = arready & ar_ok;
  assign err_push = arready & ~ar_ok;

  assign rd_req.addr = araddr[`DDR_ADDR_W+1:2];

  assign rvalid  = ~ret_empty;
  assign rdata   = ret_head.data;
  assign rresp   = ret_head.err ? RESP_SLVERR : RESP_OKAY;
  assign ret_pop = rvalid & rready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_out <= '0;
    end else if (rd_push && !(ret_pop && !ret_head.err)) begin
      rd_out <= rd_out + 1'b1;
    end else if (!rd_push && ret_pop && !ret_head.err) begin
      rd_out <= rd_out - 1'b1;
    end
  end

endmodule

// File: hw/ddr_bridge_params.svh
`ifndef DDR_BRIDGE_PARAMS_SVH
`define DDR_BRIDGE_PARAMS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define DDR_ADDR_W   24
`define DDR_DATA_W   32
`define DDR_MASK_W   4
`define AXI_ADDR_W   32
`define MEM_WORDS    4096   // Words behind the controller

// ------------------------------
// Queues and arbitration
// ------------------------------
`define QUEUE_DEPTH  16
`define LEVEL_W      5      // Holds 0..QUEUE_DEPTH
`define SWITCH_HIGH  12     // Read to write
`define SWITCH_LOW   4      // Write back to read
`define SAMPLE_RATE  16     // Cycles between mode checks
`define TURN_CYCLES  3

`endif

// File: hw/ddr_bridge_pkg.sv
`include "ddr_bridge_params.svh"

package ddr_bridge_pkg;

  // Controller command codes
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,
    CMD_READ  = 3'd1
  } app_cmd_e;

  typedef enum logic {
    MODE_READ  = 1'b0,
    MODE_WRITE = 1'b1
  } arb_mode_e;

  typedef enum logic [1:0] {
    TURN_IDLE,
    TURN_WAIT,
    TURN_OPEN
  } turn_state_e;

  typedef struct packed {
    logic [`DDR_ADDR_W-1:0] addr;   // Word address
    logic [`DDR_DATA_W-1:0] data;
    logic [`DDR_MASK_W-1:0] mask;   // 1 = byte kept
  } wr_req_t;

  typedef struct packed {
    logic [`DDR_ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [`DDR_DATA_W-1:0] data;
    logic                   err;    // Rejected in decode
  } rd_rsp_t;

endpackage

// File: hw/ddr_bridge_top.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module ddr_bridge_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // AXI4-Lite slave
  input  logic [`AXI_ADDR_W-1:0]      awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`DDR_DATA_W-1:0]      wdata,
  input  logic [`DDR_MASK_W-1:0]      wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXI_ADDR_W-1:0]      araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`DDR_DATA_W-1:0]      rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  // DDR user interface
  input  logic                        app_rdy,
  input  logic                        app_wdf_rdy,
  input  logic                        app_rd_data_valid,
  input  logic [`DDR_DATA_W-1:0]      app_rd_data,
  output logic                        app_en,
  output ddr_bridge_pkg::app_cmd_e    app_cmd,
  output logic [`DDR_ADDR_W-1:0]      app_addr,
  output logic                        app_wdf_wren,
  output logic                        app_wdf_end,
  output logic [`DDR_DATA_W-1:0]      app_wdf_data,
  output logic [`DDR_MASK_W-1:0]      app_wdf_mask
);

  ddr_bridge_pkg::wr_req_t wr_req;
  ddr_bridge_pkg::wr_req_t wr_head;
  ddr_bridge_pkg::rd_req_t rd_req;
  ddr_bridge_pkg::rd_req_t rd_head;
  ddr_bridge_pkg::rd_rsp_t ret_data;
  ddr_bridge_pkg::rd_rsp_t ret_head;

  logic                wr_push;
  logic                wr_pop;
  logic                wr_empty;
  logic                wr_full;
  logic [`LEVEL_W-1:0] wr_level;
  logic                rd_push;
  logic                rd_pop;
  logic                rd_empty;
  logic                rd_full;
  logic                rd_credit;
  logic                err_push;
  logic                err_room;
  logic                ret_push;
  logic                ret_pop;
  logic                ret_empty;
  logic [`LEVEL_W-1:0] ret_level;

  // ------------------------------
  // Decode stage
  // ------------------------------
  axil_req_decode u_decode (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .wr_push, .wr_req, .wr_full,
    .rd_push, .rd_req, .rd_full,
    .err_push, .ret_head, .ret_empty, .ret_pop,
    .ret_room (err_room)
  );

  req_fifo #(.WIDTH($bits(ddr_bridge_pkg::wr_req_t))) u_wr_q (
    .clk, .rst_n,
    .push (wr_push), .push_data (wr_req), .pop (wr_pop),
    .head (wr_head), .empty (wr_empty), .full (wr_full), .level (wr_level)
  );

  req_fifo #(.WIDTH($bits(ddr_bridge_pkg::rd_req_t))) u_rd_q (
    .clk, .rst_n,
    .push (rd_push), .push_data (rd_req), .pop (rd_pop),
    .head (rd_head), .empty (rd_empty), .full (rd_full), .level ()
  );

  // ------------------------------
  // Execute and result stages
  // ------------------------------
  ddr_cmd_arbiter u_arbiter (
    .clk, .rst_n,
    .wr_head, .wr_empty, .wr_level, .wr_pop,
    .rd_head, .rd_empty, .rd_pop, .rd_credit,
    .app_rdy, .app_wdf_rdy, .app_en, .app_cmd, .app_addr,
    .app_wdf_wren, .app_wdf_end, .app_wdf_data, .app_wdf_mask
  );

  rd_data_return u_return (
    .clk, .rst_n,
    .rd_issue (rd_pop),   // Read leaves the queue on acceptance
    .app_rd_data_valid, .app_rd_data,
    .err_push, .ret_level, .ret_push, .ret_data, .rd_credit, .err_room
  );

  req_fifo #(.WIDTH($bits(ddr_bridge_pkg::rd_rsp_t))) u_ret_q (
    .clk, .rst_n,
    .push (ret_push), .push_data (ret_data), .pop (ret_pop),
    .head (ret_head), .empty (ret_empty), .full (), .level (ret_level)
  );

endmodule

// File: hw/ddr_cmd_arbiter.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module ddr_cmd_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  // Queue heads
  input  ddr_bridge_pkg::wr_req_t       wr_head,
  input  logic                          wr_empty,
  input  logic [`LEVEL_W-1:0]           wr_level,
  output logic                          wr_pop,
  input  ddr_bridge_pkg::rd_req_t       rd_head,
  input  logic                          rd_empty,
  output logic                          rd_pop,
  input  logic                          rd_credit,
  // DDR user interface
  input  logic                          app_rdy,
  input  logic                          app_wdf_rdy,
  output logic                          app_en,
  output ddr_bridge_pkg::app_cmd_e      app_cmd,
  output logic [`DDR_ADDR_W-1:0]        app_addr,
  output logic                          app_wdf_wren,
  output logic                          app_wdf_end,
  output logic [`DDR_DATA_W-1:0]        app_wdf_data,
  output logic [`DDR_MASK_W-1:0]        app_wdf_mask
);

  localparam int SMP_W  = $clog2(`SAMPLE_RATE);
  localparam int TURN_W = $clog2(`TURN_CYCLES + 1);

  logic [SMP_W-1:0]            sample_cnt;
  logic                        sample_tick;
  ddr_bridge_pkg::arb_mode_e   mode;
  ddr_bridge_pkg::arb_mode_e   mode_nxt;
  ddr_bridge_pkg::turn_state_e turn_st;
  logic [TURN_W-1:0]           turn_cnt;
  logic                        cmd_done;    // Write command taken
  logic                        data_done;   // Write beat taken
  logic                        busy;
  logic                        wr_go;
  logic                        rd_go;
  logic                        cmd_take;
  logic                        data_take;

  // ------------------------------
  // Mode sampling
  // ------------------------------
  // New mode gets a full interval once the bus has turned
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample_cnt <= '0;
    end else if (sample_tick || turn_st == ddr_bridge_pkg::TURN_OPEN) begin
      sample_cnt <= '0;
    end else begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  assign sample_tick = (sample_cnt == SMP_W'(`SAMPLE_RATE - 1));

  always_comb begin
    mode_nxt = mode;
    if (wr_empty) begin
      mode_nxt = ddr_bridge_pkg::MODE_READ;
    end else if (rd_empty) begin
      mode_nxt = ddr_bridge_pkg::MODE_WRITE;
    end else if (wr_level >= `LEVEL_W'(`SWITCH_HIGH)) begin
      mode_nxt = ddr_bridge_pkg::MODE_WRITE;
    end else if (wr_level <= `LEVEL_W'(`SWITCH_LOW)) begin
      mode_nxt = ddr_bridge_pkg::MODE_READ;
    end
  end

  // No switch with a command or beat half way through
  assign busy = cmd_done | data_done | (app_en & ~app_rdy) | (app_wdf_wren & ~app_wdf_rdy);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode     <= ddr_bridge_pkg::MODE_READ;
      turn_st  <= ddr_bridge_pkg::TURN_IDLE;
      turn_cnt <= '0;
    end else begin
      case (turn_st)
        ddr_bridge_pkg::TURN_IDLE: begin
          if (sample_tick && !busy && mode_nxt != mode) begin
            mode     <= mode_nxt;
            turn_st  <= ddr_bridge_pkg::TURN_WAIT;
            turn_cnt <= TURN_W'(`TURN_CYCLES - 1);
          end
        end
        ddr_bridge_pkg::TURN_WAIT: begin
          if (turn_cnt == '0) begin
            turn_st <= ddr_bridge_pkg::TURN_OPEN;
          end else begin
            turn_cnt <= turn_cnt - 1'b1;
          end
        end
        default: turn_st <= ddr_bridge_pkg::TURN_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Issue
  // ------------------------------
  assign wr_go = (mode == ddr_bridge_pkg::MODE_WRITE) &
                 (turn_st != ddr_bridge_pkg::TURN_WAIT) & ~wr_empty;
  assign rd_go = (mode == ddr_bridge_pkg::MODE_READ) &
                 (turn_st != ddr_bridge_pkg::TURN_WAIT) & ~rd_empty & rd_credit;

  assign app_en       = (wr_go & ~cmd_done) | rd_go;
  assign app_wdf_wren = wr_go & ~data_done;
  assign app_wdf_end  = app_wdf_wren;   // One beat per command

  assign cmd_take  = wr_go & ~cmd_done & app_rdy;
  assign data_take = app_wdf_wren & app_wdf_rdy;
  assign wr_pop    = wr_go & (cmd_done | cmd_take) & (data_done | data_take);
  assign rd_pop    = rd_go & app_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_done  <= 1'b0;
      data_done <= 1'b0;
    end else if (wr_pop) begin
      cmd_done  <= 1'b0;
      data_done <= 1'b0;
    end else begin
      if (cmd_take)  cmd_done  <= 1'b1;
      if (data_take) data_done <= 1'b1;
    end
  end

  assign app_cmd      = (mode == ddr_bridge_pkg::MODE_WRITE) ?
                        ddr_bridge_pkg::CMD_WRITE : ddr_bridge_pkg::CMD_READ;
  assign app_addr     = (mode == ddr_bridge_pkg::MODE_WRITE) ? wr_head.addr : rd_head.addr;
  assign app_wdf_data = wr_head.data;
  assign app_wdf_mask = wr_head.mask;

endmodule

// File: hw/rd_data_return.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module rd_data_return (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rd_issue,
  input  logic                      app_rd_data_valid,
  input  logic [`DDR_DATA_W-1:0]    app_rd_data,
  input  logic                      err_push,
  input  logic [`LEVEL_W-1:0]       ret_level,
  output logic                      ret_push,
  output ddr_bridge_pkg::rd_rsp_t   ret_data,
  output logic                      rd_credit,
  output logic                      err_room
);

  logic [`LEVEL_W-1:0] in_flight;
  logic [`LEVEL_W:0]   committed;   // In flight plus already queued

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else if (rd_issue && !app_rd_data_valid) begin
      in_flight <= in_flight + 1'b1;
    end else if (!rd_issue && app_rd_data_valid) begin
      in_flight <= in_flight - 1'b1;
    end
  end

  // Returned data has no ready, so every issued read owns a slot
  assign committed = {1'b0, in_flight} + {1'b0, ret_level};
  assign rd_credit = (committed < `QUEUE_DEPTH);
  assign err_room  = (in_flight == '0) & (ret_level < `QUEUE_DEPTH);

  assign ret_push      = app_rd_data_valid | err_push;
  assign ret_data.data = app_rd_data_valid ? app_rd_data : '0;
  assign ret_data.err  = ~app_rd_data_valid;   // Marker only without DDR data

endmodule

// File: hw/req_fifo.sv
`timescale 1ns/100ps
`include "ddr_bridge_params.svh"

module req_fifo #(
  parameter int WIDTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  logic [WIDTH-1:0]    push_data,
  input  logic                pop,
  output logic [WIDTH-1:0]    head,
  output logic                empty,
  output logic                full,
  output logic [`LEVEL_W-1:0] level
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);

  logic [WIDTH-1:0] mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on the power-of-two depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) begin
        level <= level + 1'b1;
      end else if (do_pop && !do_push) begin
        level <= level - 1'b1;
      end
    end
  end

  assign head  = mem[rd_ptr];   // Fall-through
  assign empty = (level == '0);
  assign full  = (level == `LEVEL_W'(`QUEUE_DEPTH));

endmodule

// File: tb.f
+incdir+hw
hw/ddr_bridge_pkg.sv
hw/req_fifo.sv
hw/axil_req_decode.sv
hw/ddr_cmd_arbiter.sv
hw/rd_data_return.sv
hw/ddr_bridge_top.sv
dv/ddr_mem_model.sv
dv/tb_ddr_bridge.sv
